// File: Bender.yml
package:
  name: awg

export_include_dirs:
  - hdl

sources:
  - hdl/awg_pkg.sv
  - hdl/awg_dma_loader.sv
  - hdl/awg_wave_buffer.sv
  - hdl/awg_burst_sequencer.sv
  - hdl/awg_output_stage.sv
  - hdl/awg_top.sv
  - target: test
    files:
      - bench/awg_clk_gen.sv
      - bench/awg_chk.sv
      - bench/awg_tb.sv

// File: bench/awg_chk.sv
module awg_chk (
  input logic dma_clk,
  input logic rst_n_i,
  input logic xfer_error_i,
  input logic sample_valid_i,
  input logic trigger_i,
  input logic done_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // number of assertion failures so far, read by the testbench at the end
  int fail_count = 0;

  // a trigger always marks a valid sample
  trig_with_sample: assert property (@(posedge dma_clk) disable iff (!rst_n_i)
    trigger_i |-> sample_valid_i)
    else begin
      fail_count++;
      $error("trigger_o seen without sample_valid_o");
    end

  // error strobe is one cycle wide
  error_one_cycle: assert property (@(posedge dma_clk) disable iff (!rst_n_i)
    xfer_error_i |=> !xfer_error_i)
    else begin
      fail_count++;
      $error("xfer_error_o held for two cycles");
    end

  // once reset has been seen on an edge, outputs stay low while it lasts
  quiet_in_reset: assert property (@(posedge dma_clk)
    (!rst_n_i ##1 !rst_n_i) |-> !(xfer_error_i || sample_valid_i || trigger_i || done_i))
    else begin
      fail_count++;
      $error("an output is high during reset");
    end

endmodule

bind awg_top awg_chk u_chk (
  .dma_clk        (dma_clk),
  .rst_n_i        (rst_n_i),
  .xfer_error_i   (xfer_error_o),
  .sample_valid_i (sample_valid_o),
  .trigger_i      (trigger_o),
  .done_i         (done_o)
);

// File: bench/awg_clk_gen.sv
module awg_clk_gen (
  output logic dma_clk,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // free running 20 ns clock
  initial begin
    dma_clk = 1'b0;
    forever #10 dma_clk = ~dma_clk;
  end

  // reset low for 16 rising edges, released just after an edge
  initial begin
    rst_n_o = 1'b0;
    repeat (16) @(posedge dma_clk);
    #2 rst_n_o = 1'b1;
  end

endmodule

// File: bench/awg_tb.sv
`include "awg_config.svh"

module awg_tb
  import awg_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  // 13 transfers of at most depth+12 cycles, 12 runs of at most 4 bursts
  localparam int max_cycles = 16 + 13 * (`AWG_DEPTH + 12) + 12 * (4 * `AWG_DEPTH + 10);

  logic dma_clk, rst_n, cfg_valid, wr_valid, wr_last, start, stop;
  depth_t cfg_depth;
  burst_t cfg_bursts;
  trig_mode_t cfg_trig_mode;
  sample_t wr_data, sample;
  logic xfer_error, sample_valid, trigger, done;

  // reference model state
  sample_t model_mem [`AWG_DEPTH];
  int depth_m, bursts_m, mode_m;
  int cyc = 0;
  logic [15:0] lfsr = 16'd97;

  // what the monitor saw, sample index and cycle per entry
  sample_t got_data[$];
  int got_cyc[$];
  bit got_trig[$];
  int done_idx[$];
  int err_cyc[$];

  awg_clk_gen u_clk_gen (.dma_clk(dma_clk), .rst_n_o(rst_n));

  awg_top dut (
    .dma_clk(dma_clk), .rst_n_i(rst_n), .cfg_valid_i(cfg_valid), .cfg_depth_i(cfg_depth),
    .cfg_bursts_i(cfg_bursts), .cfg_trig_mode_i(cfg_trig_mode), .wr_valid_i(wr_valid),
    .wr_data_i(wr_data), .wr_last_i(wr_last), .start_i(start), .stop_i(stop),
    .xfer_error_o(xfer_error), .sample_valid_o(sample_valid), .sample_o(sample),
    .trigger_o(trigger), .done_o(done)
  );

  // cycle count, bumped on every rising edge
  always @(posedge dma_clk) cyc <= cyc + 1;

  // outputs are stable at the falling edge
  always @(negedge dma_clk) begin
    if (sample_valid) begin
      got_data.push_back(sample);
      got_cyc.push_back(cyc);
      got_trig.push_back(trigger);
    end
    if (done) done_idx.push_back(got_data.size() - 1);
    if (xfer_error) err_cyc.push_back(cyc);
  end

  // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic int unsigned random_bits(input int n);
    int unsigned r;
    int i;
    r = 0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      r = (r << 1) | lfsr[0];
    end
    return r;
  endfunction

  task automatic check(input bit ok, input string msg);
    assert (ok) else begin
      $display("Error at %0t: %s", $time, msg);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  // inputs change 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge dma_clk);
    #2;
  endtask

  task automatic configure(input int depth, input int bursts, input int mode);
    cfg_valid = 1'b1;
    cfg_depth = depth_t'(depth);
    cfg_bursts = burst_t'(bursts);
    cfg_trig_mode = trig_mode_t'(mode);
    depth_m = depth;
    bursts_m = bursts;
    mode_m = mode;
    next_cycle();
    cfg_valid = 1'b0;
  endtask

  // kind 0 correct last, 1 early last, 2 missing last
  task automatic load(input int kind);
    int n, i, last_at, bad_at, bad_cyc;
    err_cyc.delete();
    last_at = (kind == 1) ? int'(random_bits(6) % (depth_m - 1)) : depth_m - 1;
    // a missing last is followed by some discarded words and then a last
    n = (kind == 2) ? depth_m + 1 + int'(random_bits(3)) : last_at + 1;
    bad_at = (kind == 1) ? last_at : (kind == 2) ? depth_m - 1 : -1;
    bad_cyc = -1;
    for (i = 0; i < n; i++) begin
      wr_valid = 1'b1;
      wr_data = sample_t'(random_bits(`AWG_SAMPLE_W));
      wr_last = (i == n - 1);
      if (i < depth_m) model_mem[i] = wr_data;
      if (i == bad_at) bad_cyc = cyc;
      next_cycle();
    end
    wr_valid = 1'b0;
    wr_last = 1'b0;
    repeat (2) next_cycle();
    if (kind == 0) begin
      check(err_cyc.size() == 0, "xfer_error_o raised on a correct transfer");
    end else begin
      check(err_cyc.size() == 1, $sformatf("expected 1 error strobe, got %0d", err_cyc.size()));
      check(err_cyc[0] == bad_cyc + 1,
            $sformatf("error strobe in cycle %0d, expected %0d", err_cyc[0], bad_cyc + 1));
    end
  endtask

  // offsets after start for an extra start and a stop, 0 for none
  task automatic play(input int restart_at, input int stop_at);
    int s, n, k, i;
    bit exp_trig;
    got_data.delete();
    got_cyc.delete();
    got_trig.delete();
    done_idx.delete();
    n = depth_m * bursts_m;
    start = 1'b1;
    s = cyc;
    next_cycle();
    k = 1;
    // wait for done, or for the stop to have been driven
    while (done_idx.size() == 0 && !(stop_at > 0 && k > stop_at)) begin
      start = (k == restart_at);
      stop = (k == stop_at);
      next_cycle();
      k++;
    end
    start = 1'b0;
    stop = 1'b0;
    // catch stray samples or a second done
    repeat (3) next_cycle();
    if (stop_at == 0) begin
      check(got_data.size() == n, $sformatf("got %0d samples, expected %0d", got_data.size(), n));
      check(done_idx.size() == 1 && done_idx[0] == n - 1, "done_o not once with the last sample");
    end else begin
      check(done_idx.size() == 0, "done_o pulsed on a stopped run");
      // samples out before the stop was seen, plus at most 2 in flight
      check(got_data.size() >= stop_at - 2 && got_data.size() <= stop_at,
            "wrong sample count after stop");
    end
    for (i = 0; i < got_data.size(); i++) begin
      exp_trig = (i % depth_m == 0) && (mode_m == 1 || (mode_m == 2 && i == 0));
      check(got_cyc[i] == s + 3 + i,
            $sformatf("sample %0d in cycle %0d, expected %0d", i, got_cyc[i], s + 3 + i));
      check(got_data[i] == model_mem[i % depth_m], $sformatf("sample %0d is %h, expected %h",
            i, got_data[i], model_mem[i % depth_m]));
      check(got_trig[i] == exp_trig, $sformatf("trigger at sample %0d is %0b", i, got_trig[i]));
    end
  endtask

  initial begin
    cfg_valid = 1'b0;
    cfg_depth = '0;
    cfg_bursts = '0;
    cfg_trig_mode = '0;
    wr_valid = 1'b0;
    wr_data = '0;
    wr_last = 1'b0;
    start = 1'b0;
    stop = 1'b0;
    wait (rst_n === 1'b1);
    next_cycle();
    check(!xfer_error && !sample_valid && !trigger && !done && sample == '0,
          "outputs not low after reset");
    // full buffer, one burst, trigger on every burst
    configure(`AWG_DEPTH, 1, 1);
    load(0);
    play(0, 0);
    // random depth, burst count and mode
    repeat (6) begin
      configure(1 + random_bits(6), 1 + random_bits(2), random_bits(2));
      load(0);
      play(0, 0);
    end
    // early last then a clean transfer
    configure(2 + random_bits(5), 1 + random_bits(2), 1);
    load(1);
    load(0);
    play(0, 0);
    // missing last then a clean transfer
    configure(1 + random_bits(6), 2, 2);
    load(2);
    load(0);
    play(0, 0);
    // extra start while playing
    configure(1 + random_bits(6), 3, 1);
    load(0);
    play(1 + int'(random_bits(8) % (depth_m * bursts_m)), 0);
    // stop mid-run, then replay from address 0
    configure(8 + random_bits(5), 2, 1);
    load(0);
    play(0, 2 + int'(random_bits(8) % (depth_m * bursts_m - 2)));
    play(0, 0);
    // the bound protocol checker counts its own assertion failures
    if (dut.u_chk.fail_count == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("%0d protocol assertion failures in the bound checker", dut.u_chk.fail_count);
      $display("Test failures found");
      $fatal(1);
    end
  end

  // watchdog, twice the worst case length of all runs
  initial begin
    #(2 * max_cycles * 20);
    $display("Watchdog timeout: the run did not finish within %0d cycles", 2 * max_cycles);
    $display("Test failures found");
    $fatal(1);
  end

endmodule

// File: compile.f
+incdir+hdl
hdl/awg_pkg.sv
hdl/awg_dma_loader.sv
hdl/awg_wave_buffer.sv
hdl/awg_burst_sequencer.sv
hdl/awg_output_stage.sv
hdl/awg_top.sv
bench/awg_clk_gen.sv
bench/awg_chk.sv
bench/awg_tb.sv

// File: hdl/awg_burst_sequencer.sv
module awg_burst_sequencer
  import awg_pkg::*;
(
  input  logic   dma_clk,
  input  logic   rst_n_i,
  input  logic   cfg_valid_i,
  input  burst_t cfg_bursts_i,
  input  depth_t depth_i,
  input  logic   start_i,
  input  logic   stop_i,
  output logic   rd_en_o,
  output addr_t  rd_addr_o,
  output logic   first_burst_o,
  output logic   burst_start_o,
  output logic   last_o
);

  awg_state_e state_q;
  addr_t      addr_q;
  burst_t     burst_cnt_q;
  burst_t     bursts_q;
  logic       issue;
  logic       addr_end;
  logic       burst_end;
  logic       first_burst_q;
  logic       burst_start_q;
  logic       last_q;

  // one read per cycle for as long as we are playing
  assign issue     = (state_q == PLAY);
  assign rd_en_o   = issue;
  assign rd_addr_o = addr_q;

  // wrap point of the address and final pass of the burst loop
  assign addr_end  = ({1'b0, addr_q} == depth_i - 1'b1);
  assign burst_end = (burst_cnt_q == bursts_q - 1'b1);

  always_ff @(posedge dma_clk) begin
    if (!rst_n_i) begin
      state_q     <= IDLE;
      addr_q      <= '0;
      burst_cnt_q <= '0;
      bursts_q    <= '0;
    end else begin
      if (cfg_valid_i) begin
        bursts_q <= cfg_bursts_i;
      end
      case (state_q)
        IDLE: begin
          // zero bursts means nothing to play
          if (start_i && bursts_q != '0) begin
            state_q     <= PLAY;
            addr_q      <= '0;
            burst_cnt_q <= '0;
          end
        end
        PLAY: begin
          // start is ignored here, stop ends address issue right away
          if (stop_i) begin
            state_q <= IDLE;
          end else if (addr_end) begin
            addr_q <= '0;
            if (burst_end) begin
              state_q <= IDLE;
            end else begin
              burst_cnt_q <= burst_cnt_q + 1'b1;
            end
          end else begin
            addr_q <= addr_q + 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // tags delayed by one cycle to line up with the buffer read data
  always_ff @(posedge dma_clk) begin
    if (!rst_n_i) begin
      first_burst_q <= 1'b0;
      burst_start_q <= 1'b0;
      last_q        <= 1'b0;
    end else begin
      first_burst_q <= issue && burst_cnt_q == '0;
      burst_start_q <= issue && addr_q == '0;
      // an aborted run never reports done
      last_q        <= issue && addr_end && burst_end && !stop_i;
    end
  end

  assign first_burst_o = first_burst_q;
  assign burst_start_o = burst_start_q;
  assign last_o        = last_q;

endmodule

// File: hdl/awg_config.svh
`ifndef AWG_CONFIG_SVH
`define AWG_CONFIG_SVH

// width of one waveform sample, one stream word carries one sample
`define AWG_SAMPLE_W 16

// sample buffer depth
// keep it a power of two, the address width is derived from it
`define AWG_DEPTH 64

// width of the programmed burst count
`define AWG_BURST_W 8

`endif

// File: hdl/awg_dma_loader.sv
module awg_dma_loader
  import awg_pkg::*;
(
  input  logic    dma_clk,
  input  logic    rst_n_i,
  input  logic    cfg_valid_i,
  input  depth_t  cfg_depth_i,
  input  logic    wr_valid_i,
  input  sample_t wr_data_i,
  input  logic    wr_last_i,
  output logic    buf_we_o,
  output addr_t   buf_waddr_o,
  output sample_t buf_wdata_o,
  output depth_t  depth_o,
  output logic    xfer_error_o
);

  // full buffer, the depth register comes out of reset with this
  localparam depth_t depth_max = depth_t'(2 ** $bits(addr_t));

  depth_t depth_q;
  addr_t  idx_q;
  logic   discard_q;
  logic   err_q;
  logic   at_end;

  // current word is the configured final word of the waveform
  assign at_end = ({1'b0, idx_q} == depth_q - 1'b1);

  // words are dropped while waiting for the last flag of a bad transfer
  assign buf_we_o    = wr_valid_i & ~discard_q;
  assign buf_waddr_o = idx_q;
  assign buf_wdata_o = wr_data_i;

  assign depth_o      = depth_q;
  assign xfer_error_o = err_q;

  always_ff @(posedge dma_clk) begin
    if (!rst_n_i) begin
      depth_q   <= depth_max;
      idx_q     <= '0;
      discard_q <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      // error is a single cycle strobe
      err_q <= 1'b0;
      if (cfg_valid_i) begin
        depth_q <= cfg_depth_i;
      end
      if (wr_valid_i) begin
        if (discard_q) begin
          // resync on the next last flag, index already back at 0
          if (wr_last_i) begin
            discard_q <= 1'b0;
          end
        end else if (wr_last_i) begin
          // end of transfer, early last is flagged
          idx_q <= '0;
          err_q <= ~at_end;
        end else if (at_end) begin
          // last flag missing on the final word
          idx_q     <= '0;
          discard_q <= 1'b1;
          err_q     <= 1'b1;
        end else begin
          idx_q <= idx_q + 1'b1;
        end
      end
    end
  end

endmodule

// File: hdl/awg_output_stage.sv
module awg_output_stage
  import awg_pkg::*;
(
  input  logic       dma_clk,
  input  logic       rst_n_i,
  input  logic       cfg_valid_i,
  input  trig_mode_t cfg_trig_mode_i,
  input  logic       rd_valid_i,
  input  sample_t    rd_data_i,
  input  logic       first_burst_i,
  input  logic       burst_start_i,
  input  logic       last_i,
  output logic       sample_valid_o,
  output sample_t    sample_o,
  output logic       trigger_o,
  output logic       done_o
);

  trig_mode_t mode_q;
  logic       trig_next;

  // mode 1 fires on every burst start, mode 2 on the first burst only
  always_comb begin
    case (mode_q)
      2'd1:    trig_next = rd_valid_i & burst_start_i;
      2'd2:    trig_next = rd_valid_i & burst_start_i & first_burst_i;
      default: trig_next = 1'b0;
    endcase
  end

  always_ff @(posedge dma_clk) begin
    if (!rst_n_i) begin
      mode_q         <= '0;
      sample_valid_o <= 1'b0;
      sample_o       <= '0;
      trigger_o      <= 1'b0;
      done_o         <= 1'b0;
    end else begin
      if (cfg_valid_i) begin
        mode_q <= cfg_trig_mode_i;
      end
      // sample, valid, trigger and done leave on the same edge
      sample_valid_o <= rd_valid_i;
      if (rd_valid_i) begin
        sample_o <= rd_data_i;
      end
      trigger_o <= trig_next;
      done_o    <= rd_valid_i & last_i;
    end
  end

endmodule

// File: hdl/awg_pkg.sv
`include "awg_config.svh"

package awg_pkg;

  // one waveform sample
  typedef logic [`AWG_SAMPLE_W-1:0] sample_t;

  // sample buffer address
  typedef logic [$clog2(`AWG_DEPTH)-1:0] addr_t;

  // waveform length 1..AWG_DEPTH, needs one bit above the address
  typedef logic [$clog2(`AWG_DEPTH):0] depth_t;

  // number of back to back bursts per start
  typedef logic [`AWG_BURST_W-1:0] burst_t;

  // trigger mode: 0 none, 1 every burst, 2 first burst only, 3 none
  typedef logic [1:0] trig_mode_t;

  // burst sequencer states
  typedef enum logic {IDLE, PLAY} awg_state_e;

endpackage

// File: hdl/awg_top.sv
module awg_top
  import awg_pkg::*;
(
  input  logic       dma_clk,
  input  logic       rst_n_i,
  input  logic       cfg_valid_i,
  input  depth_t     cfg_depth_i,
  input  burst_t     cfg_bursts_i,
  input  trig_mode_t cfg_trig_mode_i,
  input  logic       wr_valid_i,
  input  sample_t    wr_data_i,
  input  logic       wr_last_i,
  input  logic       start_i,
  input  logic       stop_i,
  output logic       xfer_error_o,
  output logic       sample_valid_o,
  output sample_t    sample_o,
  output logic       trigger_o,
  output logic       done_o
);

  // loader write port into the buffer
  logic    buf_we;
  addr_t   buf_waddr;
  sample_t buf_wdata;
  depth_t  depth;

  // sequencer read port and tags
  logic    rd_en;
  addr_t   rd_addr;
  sample_t rd_data;
  logic    rd_valid;
  logic    rd_first_burst;
  logic    rd_burst_start;
  logic    rd_last;

  // each block latches its own field on cfg_valid_i
  awg_dma_loader u_loader (
    .dma_clk      (dma_clk),
    .rst_n_i      (rst_n_i),
    .cfg_valid_i  (cfg_valid_i),
    .cfg_depth_i  (cfg_depth_i),
    .wr_valid_i   (wr_valid_i),
    .wr_data_i    (wr_data_i),
    .wr_last_i    (wr_last_i),
    .buf_we_o     (buf_we),
    .buf_waddr_o  (buf_waddr),
    .buf_wdata_o  (buf_wdata),
    .depth_o      (depth),
    .xfer_error_o (xfer_error_o)
  );

  awg_wave_buffer u_buffer (
    .dma_clk     (dma_clk),
    .buf_we_i    (buf_we),
    .buf_waddr_i (buf_waddr),
    .buf_wdata_i (buf_wdata),
    .rd_en_i     (rd_en),
    .rd_addr_i   (rd_addr),
    .rd_data_o   (rd_data),
    .rd_valid_o  (rd_valid)
  );

  awg_burst_sequencer u_sequencer (
    .dma_clk       (dma_clk),
    .rst_n_i       (rst_n_i),
    .cfg_valid_i   (cfg_valid_i),
    .cfg_bursts_i  (cfg_bursts_i),
    .depth_i       (depth),
    .start_i       (start_i),
    .stop_i        (stop_i),
    .rd_en_o       (rd_en),
    .rd_addr_o     (rd_addr),
    .first_burst_o (rd_first_burst),
    .burst_start_o (rd_burst_start),
    .last_o        (rd_last)
  );

  awg_output_stage u_output (
    .dma_clk         (dma_clk),
    .rst_n_i         (rst_n_i),
    .cfg_valid_i     (cfg_valid_i),
    .cfg_trig_mode_i (cfg_trig_mode_i),
    .rd_valid_i      (rd_valid),
    .rd_data_i       (rd_data),
    .first_burst_i   (rd_first_burst),
    .burst_start_i   (rd_burst_start),
    .last_i          (rd_last),
    .sample_valid_o  (sample_valid_o),
    .sample_o        (sample_o),
    .trigger_o       (trigger_o),
    .done_o          (done_o)
  );

endmodule

// File: hdl/awg_wave_buffer.sv
module awg_wave_buffer
  import awg_pkg::*;
(
  input  logic    dma_clk,
  input  logic    buf_we_i,
  input  addr_t   buf_waddr_i,
  input  sample_t buf_wdata_i,
  input  logic    rd_en_i,
  input  addr_t   rd_addr_i,
  output sample_t rd_data_o,
  output logic    rd_valid_o
);

  // one entry per address, so AWG_DEPTH samples
  sample_t mem [2 ** $bits(addr_t)];
  sample_t rd_data_q;
  logic    rd_valid_q;

  always_ff @(posedge dma_clk) begin
    if (buf_we_i) begin
      mem[buf_waddr_i] <= buf_wdata_i;
    end
    // registered read, data follows rd_en by one cycle
    if (rd_en_i) begin
      rd_data_q <= mem[rd_addr_i];
    end
    rd_valid_q <= rd_en_i;
  end

  assign rd_data_o  = rd_data_q;
  assign rd_valid_o = rd_valid_q;

endmodule
